//--- logic/apb_timer_regs.sv
// Zero-wait APB slave for the timer, holds control and mtimecmp and forwards mtime writes
`timescale 1ns/1ps
`include "timer_defs.svh"

module apb_timer_regs (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  timer_pkg::apb_addr_t paddr,
	input  timer_pkg::apb_word_t pwdata,
	output timer_pkg::apb_word_t prdata,
	output logic                pready,
	output logic                pslverr,

	timer_regs_if.regs          regs
);
	import timer_pkg::*;

	// ------------------------------
	// decode
	// ------------------------------

	logic access;
	logic wr_en;
	logic sel_ctrl;
	logic sel_mtime_lo;
	logic sel_mtime_hi;
	logic sel_cmp_lo;
	logic sel_cmp_hi;
	logic mapped;

	// access phase of a transfer, completes at this edge
	assign access = psel && penable;
	assign wr_en  = access && pwrite;

	// full address compare, so an unaligned paddr never hits a register
	assign sel_ctrl     = (paddr == `TIMER_ADDR_CTRL);
	assign sel_mtime_lo = (paddr == `TIMER_ADDR_MTIME_LO);
	assign sel_mtime_hi = (paddr == `TIMER_ADDR_MTIME_HI);
	assign sel_cmp_lo   = (paddr == `TIMER_ADDR_MTIMECMP_LO);
	assign sel_cmp_hi   = (paddr == `TIMER_ADDR_MTIMECMP_HI);

	assign mapped = sel_ctrl || sel_mtime_lo || sel_mtime_hi || sel_cmp_lo || sel_cmp_hi;

	// no wait states
	assign pready  = 1'b1;
	assign pslverr = access && !mapped;

	// ------------------------------
	// control and compare registers
	// ------------------------------

	logic   enable_q;
	mtime_t mtimecmp_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable_q   <= 1'b0;
			mtimecmp_q <= `TIMER_MTIMECMP_RESET;
		end else if (wr_en) begin
			if (sel_ctrl) begin
				enable_q <= pwdata[0];
			end
			if (sel_cmp_lo) begin
				mtimecmp_q[31:0] <= pwdata;
			end
			if (sel_cmp_hi) begin
				mtimecmp_q[63:32] <= pwdata;
			end
		end
	end

	assign regs.enable   = enable_q;
	assign regs.mtimecmp = mtimecmp_q;

	// mtime lives in the counter; hand over data plus a one-cycle strobe
	assign regs.mtime_wdata = pwdata;
	assign regs.mtime_wr_lo = wr_en && sel_mtime_lo;
	assign regs.mtime_wr_hi = wr_en && sel_mtime_hi;

	// ------------------------------
	// read mux
	// ------------------------------

	apb_word_t rdata;

	always_comb begin
		rdata = '0;
		if (sel_ctrl) begin
			rdata = {31'd0, enable_q};
		end
		if (sel_mtime_lo) begin
			rdata = regs.mtime[31:0];
		end
		if (sel_mtime_hi) begin
			rdata = regs.mtime[63:32];
		end
		if (sel_cmp_lo) begin
			rdata = mtimecmp_q[31:0];
		end
		if (sel_cmp_hi) begin
			rdata = mtimecmp_q[63:32];
		end
	end

	// bus idles at zero outside the access phase
	assign prdata = access ? rdata : '0;

endmodule

//--- logic/mtime_counter.sv
// 64-bit mtime counter with debug freeze, software load and registered compare interrupt
`timescale 1ns/1ps

module mtime_counter (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          tick,
	input  logic          dbg_halt,
	timer_regs_if.counter cnt,
	output logic          timer_irq
);
	import timer_pkg::*;

	mtime_t mtime_q;
	mtime_t mtime_next;
	logic   count_en;

	// time stands still while the hart is halted by the debugger
	assign count_en = tick && cnt.enable && !dbg_halt;

	// ------------------------------
	// next value
	// ------------------------------

	always_comb begin
		mtime_next = mtime_q;
		if (cnt.mtime_wr_lo || cnt.mtime_wr_hi) begin
			// software write wins over the tick for the whole counter
			if (cnt.mtime_wr_lo) begin
				mtime_next[31:0] = cnt.mtime_wdata;
			end
			if (cnt.mtime_wr_hi) begin
				mtime_next[63:32] = cnt.mtime_wdata;
			end
		end else if (count_en) begin
			mtime_next = mtime_q + 64'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime_q <= '0;
		end else begin
			mtime_q <= mtime_next;
		end
	end

	assign cnt.mtime = mtime_q;

	// ------------------------------
	// compare
	// ------------------------------

	// one cycle behind the registered mtime and mtimecmp values
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime_q >= cnt.mtimecmp);
		end
	end

endmodule

//--- logic/riscv_timer_top.sv
// Top level of the RISC-V machine timer, APB slave port plus timebase, debug halt and irq
`timescale 1ns/1ps
`include "timer_defs.svh"

module riscv_timer_top (
	input  logic                 clk,
	input  logic                 rst_n,

	// APB slave
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  timer_pkg::apb_addr_t paddr,
	input  timer_pkg::apb_word_t pwdata,
	output timer_pkg::apb_word_t prdata,
	output logic                 pready,
	output logic                 pslverr,

	// hart halted by the debugger
	input  logic                 dbg_halt,
	output logic                 timer_irq
);

	logic us_tick;

	timer_regs_if regs_if ();

	// ------------------------------
	// timebase
	// ------------------------------

	us_timebase #(
		.clk_mhz (`TIMER_CLK_MHZ)
	) u_timebase (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (us_tick)
	);

	// ------------------------------
	// register block
	// ------------------------------

	apb_timer_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.regs    (regs_if.regs)
	);

	// counter and compare
	mtime_counter u_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (us_tick),
		.dbg_halt  (dbg_halt),
		.cnt       (regs_if.counter),
		.timer_irq (timer_irq)
	);

endmodule

//--- logic/timer_defs.svh
// Clock rate, register map and reset values for the machine timer, included by RTL and testbench
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// clock cycles per microsecond
`define TIMER_CLK_MHZ 4

// ------------------------------
// register byte offsets
// ------------------------------
`define TIMER_ADDR_CTRL        16'h0000
`define TIMER_ADDR_MTIME_LO    16'h0008
`define TIMER_ADDR_MTIME_HI    16'h000c
`define TIMER_ADDR_MTIMECMP_LO 16'h0010
`define TIMER_ADDR_MTIMECMP_HI 16'h0014

// compare value out of reach, so no interrupt after reset
`define TIMER_MTIMECMP_RESET 64'hffff_ffff_ffff_ffff

`endif

//--- logic/timer_pkg.sv
// Bus and time value types shared by the machine timer RTL and its testbench
package timer_pkg;

	// ------------------------------
	// APB side
	// ------------------------------

	// byte address seen by the timer slave
	typedef logic [15:0] apb_addr_t;

	// one APB data word
	typedef logic [31:0] apb_word_t;

	// ------------------------------
	// time base
	// ------------------------------

	// mtime and mtimecmp, in microseconds
	typedef logic [63:0] mtime_t;

endpackage

//--- logic/timer_regs_if.sv
// Register state between the APB register block and the mtime counter, one instance per timer
`timescale 1ns/1ps

interface timer_regs_if;
	import timer_pkg::*;

	// control and compare, owned by the register block
	logic      enable;
	mtime_t    mtimecmp;

	// software load of one mtime half, strobes last a single cycle
	apb_word_t mtime_wdata;
	logic      mtime_wr_lo;
	logic      mtime_wr_hi;

	// live counter value for readback
	mtime_t    mtime;

	modport regs (
		output enable, mtimecmp, mtime_wdata, mtime_wr_lo, mtime_wr_hi,
		input  mtime
	);

	modport counter (
		input  enable, mtimecmp, mtime_wdata, mtime_wr_lo, mtime_wr_hi,
		output mtime
	);

endinterface

//--- logic/us_timebase.sv
// Microsecond prescaler, emits a one-cycle tick every clk_mhz system clocks
`timescale 1ns/1ps
`include "timer_defs.svh"

module us_timebase #(
	parameter int clk_mhz = `TIMER_CLK_MHZ
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	// one bit minimum so clk_mhz of 1 still builds
	localparam int ctr_w = (clk_mhz > 1) ? $clog2(clk_mhz) : 1;
	localparam logic [ctr_w-1:0] reload = ctr_w'(clk_mhz - 1);

	logic [ctr_w-1:0] ctr;

	// starts at reload, so the first tick lands clk_mhz cycles out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctr  <= reload;
			tick <= 1'b0;
		end else begin
			if (ctr == '0) begin
				ctr <= reload;
			end else begin
				ctr <= ctr - 1'b1;
			end
			// registered, high in the cycle after the zero count
			tick <= (ctr == '0);
		end
	end

endmodule

//--- testbench/tb_riscv_timer.sv
// Testbench for the machine timer, runs a table of APB transfers and idle runs against the DUT
`timescale 1ns/1ps
`include "timer_defs.svh"

module tb_riscv_timer;
	import timer_pkg::*;

	localparam int op_wr   = 0;
	localparam int op_rd   = 1;
	localparam int op_idle = 2;
	localparam int count_start = 100;
	localparam int count_k     = 40;

	typedef struct {
		int        op;
		apb_addr_t off;
		apb_word_t wdata;
		apb_word_t lo;
		apb_word_t hi;
		logic      err;
		logic      irq;
		logic      halt;
	} entry_t;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_word_t pwdata;
	apb_word_t prdata;
	logic      pready;
	logic      pslverr;
	logic      dbg_halt;
	logic      timer_irq;
	apb_word_t exp_lo;
	apb_word_t exp_hi;
	logic      exp_err;
	logic      exp_irq;
	int        errors;
	int        checks;
	int        limit;
	entry_t    table_q[$];

	riscv_timer_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	timer_scoreboard i_scoreboard (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.timer_irq (timer_irq),
		.exp_lo    (exp_lo),
		.exp_hi    (exp_hi),
		.exp_err   (exp_err),
		.exp_irq   (exp_irq),
		.errors    (errors),
		.checks    (checks)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic add_entry(input int op, input apb_addr_t off, input apb_word_t wdata,
		input apb_word_t lo, input apb_word_t hi, input logic err, input logic irq,
		input logic halt);
		entry_t e;
		e.op = op;
		e.off = off;
		e.wdata = wdata;
		e.lo = lo;
		e.hi = hi;
		e.err = err;
		e.irq = irq;
		e.halt = halt;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		// reset values
		add_entry(op_idle, 0, 4, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_CTRL, 0, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_HI, 0, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIMECMP_LO, 0, '1, '1, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIMECMP_HI, 0, '1, '1, 0, 0, 0);
		// readback, one half at a time
		add_entry(op_wr, `TIMER_ADDR_MTIMECMP_LO, 32'h1234_5678, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIMECMP_LO, 0, 32'h1234_5678, 32'h1234_5678, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIMECMP_HI, 0, '1, '1, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIMECMP_HI, 32'h0000_00a5, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIMECMP_HI, 0, 32'h0000_00a5, 32'h0000_00a5, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIMECMP_LO, 0, 32'h1234_5678, 32'h1234_5678, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIME_LO, 32'hdead_beef, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0, 32'hdead_beef, 32'hdead_beef, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIME_HI, 32'h1, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_HI, 0, 32'h1, 32'h1, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0, 32'hdead_beef, 32'hdead_beef, 0, 0, 0);
		// unmapped and unaligned offsets
		add_entry(op_wr, 16'h0018, 32'h5555_5555, 0, 0, 1, 0, 0);
		add_entry(op_rd, 16'h0018, 0, 0, 0, 1, 0, 0);
		add_entry(op_rd, 16'h0002, 0, 0, 0, 1, 0, 0);
		// counting window of count_k cycles
		add_entry(op_wr, `TIMER_ADDR_MTIME_LO, count_start, 0, 0, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_CTRL, 1, 0, 0, 0, 0, 0);
		add_entry(op_idle, 0, count_k, 0, 0, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_CTRL, 0, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0,
			count_start + count_k / `TIMER_CLK_MHZ - 1,
			count_start + (count_k + `TIMER_CLK_MHZ - 1) / `TIMER_CLK_MHZ + 2, 0, 0, 0);
		// debug freeze
		add_entry(op_idle, 0, 2, 0, 0, 0, 0, 1);
		add_entry(op_wr, `TIMER_ADDR_MTIME_LO, 500, 0, 0, 0, 0, 1);
		add_entry(op_wr, `TIMER_ADDR_CTRL, 1, 0, 0, 0, 0, 1);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0, 500, 500, 0, 0, 1);
		add_entry(op_idle, 0, 40, 0, 0, 0, 0, 1);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0, 500, 500, 0, 0, 1);
		add_entry(op_idle, 0, 40, 0, 0, 0, 0, 0);
		add_entry(op_rd, `TIMER_ADDR_MTIME_LO, 0, 501, 600, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_CTRL, 0, 0, 0, 0, 0, 0);
		// interrupt on and off
		add_entry(op_wr, `TIMER_ADDR_MTIME_HI, 0, 0, 0, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIMECMP_HI, 0, 0, 0, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIME_LO, 1000, 0, 0, 0, 0, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIMECMP_LO, 1000, 0, 0, 0, 1, 0);
		add_entry(op_wr, `TIMER_ADDR_MTIMECMP_LO, 5000, 0, 0, 0, 0, 0);
	endtask

	task automatic apply_entry(input entry_t e);
		if (e.op == op_idle) begin
			@(posedge clk);
			psel <= 1'b0;
			penable <= 1'b0;
			dbg_halt <= e.halt;
			repeat (e.wdata - 1) @(posedge clk);
		end else begin
			@(posedge clk);
			psel <= 1'b1;
			penable <= 1'b0;
			pwrite <= (e.op == op_wr);
			paddr <= e.off;
			pwdata <= e.wdata;
			dbg_halt <= e.halt;
			@(posedge clk);
			penable <= 1'b1;
			exp_lo <= e.lo;
			exp_hi <= e.hi;
			exp_err <= e.err;
			exp_irq <= e.irq;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dbg_halt = 1'b0;
		exp_lo = '0;
		exp_hi = '0;
		exp_err = 1'b0;
		exp_irq = 1'b0;
		build_table();
		limit = 3 + 50;
		foreach (table_q[i]) begin
			limit += (table_q[i].op == op_idle) ? int'(table_q[i].wdata) : 2;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		foreach (table_q[i]) begin
			apply_entry(table_q[i]);
		end
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		// let the last irq check land
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#1;
		#(limit * 8);
		$display("watchdog: the run did not finish within %0d clock cycles", limit);
		$display("tests failed");
		$finish;
	end

endmodule

//--- testbench/timer_checker.sv
// Bound assertions for the timer, APB phase order and irq against the compare result
`timescale 1ns/1ps

module timer_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              timer_irq,
	input  timer_pkg::mtime_t mtime,
	input  timer_pkg::mtime_t mtimecmp
);

	// access phase only right after a setup phase
	assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel && $past(psel && !penable))
		else $error("penable high without a preceding setup phase");

	// irq follows the compare one cycle late
	assert property (@(posedge clk) disable iff (!rst_n)
		timer_irq |-> $past(mtime >= mtimecmp))
		else $error("timer_irq high while mtime was below mtimecmp");

endmodule

bind riscv_timer_top timer_checker i_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.psel      (psel),
	.penable   (penable),
	.timer_irq (timer_irq),
	.mtime     (regs_if.mtime),
	.mtimecmp  (regs_if.mtimecmp)
);

//--- testbench/timer_scoreboard.sv
// Watches the timer ports and compares read data, pslverr and irq with the expected values
`timescale 1ns/1ps

module timer_scoreboard (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  timer_pkg::apb_word_t prdata,
	input  logic                 pready,
	input  logic                 pslverr,
	input  logic                 timer_irq,
	input  timer_pkg::apb_word_t exp_lo,
	input  timer_pkg::apb_word_t exp_hi,
	input  logic                 exp_err,
	input  logic                 exp_irq,
	output int                   errors,
	output int                   checks
);

	logic irq_wait;
	logic irq_wait_exp;
	logic irq_due;
	logic irq_due_exp;

	initial begin
		errors = 0;
		checks = 0;
		irq_wait = 1'b0;
		irq_due = 1'b0;
		irq_wait_exp = 1'b0;
		irq_due_exp = 1'b0;
	end

	// mid-cycle sampling, all inputs settled
	always @(negedge clk) begin
		if (rst_n) begin
			if (irq_due) begin
				checks++;
				if (timer_irq !== irq_due_exp) begin
					errors++;
					$display("[ERROR] %0t timer_irq expected %0b actual %0b",
						$time, irq_due_exp, timer_irq);
				end
			end
			irq_due = irq_wait;
			irq_due_exp = irq_wait_exp;
			irq_wait = psel && penable && pwrite;
			irq_wait_exp = exp_irq;
			if (psel && penable) begin
				checks++;
				// zero-wait slave, every access completes in one cycle
				if (pready !== 1'b1) begin
					errors++;
					$display("[ERROR] %0t pready expected 1 actual %0b",
						$time, pready);
				end
				if (pslverr !== exp_err) begin
					errors++;
					$display("[ERROR] %0t pslverr expected %0b actual %0b",
						$time, exp_err, pslverr);
				end
				if (!pwrite && (prdata < exp_lo || prdata > exp_hi || $isunknown(prdata))) begin
					errors++;
					$display("[ERROR] %0t prdata expected %0h..%0h actual %0h",
						$time, exp_lo, exp_hi, prdata);
				end
			end
		end
	end

endmodule

//--- verilog.f
+incdir+logic
logic/timer_pkg.sv
logic/timer_regs_if.sv
logic/us_timebase.sv
logic/apb_timer_regs.sv
logic/mtime_counter.sv
logic/riscv_timer_top.sv
testbench/timer_checker.sv
testbench/timer_scoreboard.sv
testbench/tb_riscv_timer.sv
